/* design/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// word address and data widths
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// block geometry
`define CACHE_WORDS 4
`define CACHE_OFFSET_W 2

// sets per way
`define CACHE_INDEX_W 6
`define CACHE_SETS 64

`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

/* design/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// word 0 sits in the low bits
	typedef word_t [`CACHE_WORDS-1:0] block_t;

	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	// one tag ram entry per way and set
	typedef struct packed {
		logic valid;
		logic used; // most recently touched way of the set
		logic dirty;
		logic [`CACHE_TAG_W-1:0] tag;
	} tag_entry_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		EVICT, // write-back of dirty victim
		FILL,
		UPDATE
	} cache_state_t;

endpackage

/* design/cache_way_ram.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_way_ram import cache_pkg::*; #(
	parameter type entry_t = word_t
) (
	input  logic   clk,
	input  logic   reset,
	input  index_t index,
	input  entry_t d,
	input  logic   we,
	output entry_t q
);

	entry_t mem [`CACHE_SETS];

	// registered read returns the old contents on a same-cycle write
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `CACHE_SETS; i++)
				mem[i] <= '0;
			q <= '0;
		end else begin
			if (we)
				mem[index] <= d;
			q <= mem[index];
		end
	end

endmodule

/* design/cache_lookup.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_lookup import cache_pkg::*; (
	input  tag_entry_t              tag_q0,
	input  tag_entry_t              tag_q1,
	input  block_t                  block_q0,
	input  block_t                  block_q1,
	input  logic [`CACHE_TAG_W-1:0] req_tag,
	input  offset_t                 req_offset,
	input  word_t                   wdata,
	input  logic                    is_write,
	input  block_t                  fill_block,
	input  logic                    use_fill,
	output logic                    hit,
	output logic                    hit_way,
	output logic                    victim_way,
	output word_t                   word_q,
	output block_t                  line_d
);

	logic hit0;
	logic hit1;
	block_t base;

	assign hit0 = tag_q0.valid && (tag_q0.tag == req_tag);
	assign hit1 = tag_q1.valid && (tag_q1.tag == req_tag);
	assign hit = hit0 || hit1;
	assign hit_way = hit1; // only meaningful with hit

	// invalid way first, way 0 before way 1, else the unused one
	assign victim_way = tag_q0.valid && (!tag_q1.valid || tag_q0.used);

	always_comb begin
		base = use_fill ? fill_block : (hit_way ? block_q1 : block_q0);
		word_q = base[req_offset];
		line_d = base;
		if (is_write)
			line_d[req_offset] = wdata; // merge the store
	end

endmodule

/* design/line_transfer.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module line_transfer import cache_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start_fill,
	input  logic                     start_evict,
	input  logic [`CACHE_ADDR_W-1:0] block_addr,
	input  block_t                   evict_block,
	input  logic                     ready_mem,
	input  word_t                    rdata_mem,
	output logic                     read_mem,
	output logic                     write_mem,
	output logic [`CACHE_ADDR_W-1:0] addr_mem,
	output word_t                    wdata_mem,
	output block_t                   fill_block,
	output logic                     xfer_done
);

	offset_t count; // words moved so far
	block_t evict_q;
	logic beat;
	logic last;

	assign beat = (read_mem || write_mem) && ready_mem;
	assign last = beat && (count == offset_t'(`CACHE_WORDS - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			read_mem <= 1'b0;
			write_mem <= 1'b0;
			addr_mem <= '0;
			count <= '0;
			xfer_done <= 1'b0;
		end else begin
			xfer_done <= last; // same edge the level drops
			if (start_fill || start_evict) begin
				read_mem <= start_fill;
				write_mem <= start_evict;
				addr_mem <= {block_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W],
					{`CACHE_OFFSET_W{1'b0}}};
				count <= '0;
			end else if (beat) begin
				count <= count + 1'b1;
				if (last) begin
					read_mem <= 1'b0;
					write_mem <= 1'b0;
				end
			end
		end
	end

	// word 0 moves first through both shift registers
	always_ff @(posedge clk) begin
		if (start_evict)
			evict_q <= evict_block;
		else if (write_mem && ready_mem)
			evict_q <= {word_t'('0), evict_q[`CACHE_WORDS-1:1]};
		if (read_mem && ready_mem)
			fill_block <= {rdata_mem, fill_block[`CACHE_WORDS-1:1]};
	end

	assign wdata_mem = evict_q[0];

endmodule

/* design/cache_fsm.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_fsm import cache_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     read_up,
	input  logic                     write_up,
	input  logic [`CACHE_ADDR_W-1:0] addr_up,
	input  word_t                    data_up,
	input  logic                     hit,
	input  logic                     hit_way,
	input  logic                     victim_way,
	input  tag_entry_t               tag_q0,
	input  tag_entry_t               tag_q1,
	input  block_t                   block_q0,
	input  block_t                   block_q1,
	input  word_t                    word_q,
	input  logic                     xfer_done,
	output index_t                   ram_index,
	output logic [`CACHE_TAG_W-1:0]  req_tag,
	output offset_t                  req_offset,
	output word_t                    wdata,
	output logic                     is_write,
	output logic                     use_fill,
	output tag_entry_t               tag_d0,
	output tag_entry_t               tag_d1,
	output logic                     tag_we,
	output logic                     data_we0,
	output logic                     data_we1,
	output logic                     start_fill,
	output logic                     start_evict,
	output logic [`CACHE_ADDR_W-1:0] block_addr,
	output block_t                   evict_block,
	output word_t                    rdata_up,
	output logic                     stall_up
);

	localparam int IDX_LO = `CACHE_OFFSET_W;
	localparam int TAG_LO = `CACHE_OFFSET_W + `CACHE_INDEX_W;

	cache_state_t state;
	cache_state_t next_state;
	logic [`CACHE_ADDR_W-1:0] addr_q;
	index_t req_index;
	tag_entry_t victim_entry;
	logic victim_dirty;
	logic accept;
	logic hit_done;
	logic acc_way; // way touched by this access

	assign accept = (state == IDLE) && (read_up || write_up) && !stall_up;
	assign hit_done = (state == LOOKUP) && hit;
	assign use_fill = (state == UPDATE);

	// address fields
	assign req_tag = addr_q[`CACHE_ADDR_W-1:TAG_LO];
	assign req_index = addr_q[TAG_LO-1:IDX_LO];
	assign req_offset = addr_q[IDX_LO-1:0];
	assign ram_index = (state == IDLE) ? addr_up[TAG_LO-1:IDX_LO] : req_index;

	assign victim_entry = victim_way ? tag_q1 : tag_q0;
	assign victim_dirty = victim_entry.valid && victim_entry.dirty;
	assign evict_block = victim_way ? block_q1 : block_q0;
	assign acc_way = use_fill ? victim_way : hit_way;

	// transfer requests
	assign start_evict = (state == LOOKUP) && !hit && victim_dirty;
	assign start_fill = ((state == LOOKUP) && !hit && !victim_dirty)
		|| ((state == EVICT) && xfer_done);
	assign block_addr = start_evict
		? {victim_entry.tag, req_index, {`CACHE_OFFSET_W{1'b0}}}
		: {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};

	// ram writes land on the edge that ends the access
	assign tag_we = hit_done || use_fill;
	assign data_we0 = ((hit_done && is_write) || use_fill) && !acc_way;
	assign data_we1 = ((hit_done && is_write) || use_fill) && acc_way;

	always_comb begin
		tag_d0 = tag_q0;
		tag_d1 = tag_q1;
		tag_d0.used = !acc_way;
		tag_d1.used = acc_way;
		if (acc_way) begin
			tag_d1.valid = 1'b1;
			tag_d1.tag = req_tag;
			tag_d1.dirty = is_write || (tag_q1.dirty && !use_fill); // refill starts clean
		end else begin
			tag_d0.valid = 1'b1;
			tag_d0.tag = req_tag;
			tag_d0.dirty = is_write || (tag_q0.dirty && !use_fill);
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: if (accept) next_state = LOOKUP;
			LOOKUP: begin
				if (hit)
					next_state = IDLE;
				else if (victim_dirty)
					next_state = EVICT;
				else
					next_state = FILL;
			end
			EVICT: if (xfer_done) next_state = FILL;
			FILL: if (xfer_done) next_state = UPDATE;
			UPDATE: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= IDLE;
			stall_up <= 1'b0;
		end else begin
			state <= next_state;
			if (accept)
				stall_up <= 1'b1;
			else if (hit_done || use_fill)
				stall_up <= 1'b0;
		end
	end

	// request latch and read return
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= addr_up;
			wdata <= data_up;
			is_write <= write_up;
		end
		if (hit_done || use_fill)
			rdata_up <= word_q;
	end

endmodule

/* design/cache_controller.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_controller import cache_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	// processor side
	input  logic                     read_up,
	input  logic                     write_up,
	input  logic [`CACHE_ADDR_W-1:0] addr_up,
	input  word_t                    data_up,
	output word_t                    rdata_up,
	output logic                     stall_up,
	// memory side
	output logic                     read_mem,
	output logic                     write_mem,
	output logic [`CACHE_ADDR_W-1:0] addr_mem,
	output word_t                    wdata_mem,
	input  logic                     ready_mem,
	input  word_t                    rdata_mem
);

	index_t ram_index;
	tag_entry_t tag_q0;
	tag_entry_t tag_q1;
	tag_entry_t tag_d0;
	tag_entry_t tag_d1;
	block_t block_q0;
	block_t block_q1;
	block_t line_d;
	block_t fill_block;
	block_t evict_block;
	logic [`CACHE_TAG_W-1:0] req_tag;
	offset_t req_offset;
	word_t wdata;
	word_t word_q;
	logic is_write;
	logic use_fill;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic tag_we;
	logic data_we0;
	logic data_we1;
	logic start_fill;
	logic start_evict;
	logic xfer_done;
	logic [`CACHE_ADDR_W-1:0] block_addr;

	cache_fsm u_cache_fsm (
		.clk(clk), .reset(reset),
		.read_up(read_up), .write_up(write_up),
		.addr_up(addr_up), .data_up(data_up),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.tag_q0(tag_q0), .tag_q1(tag_q1),
		.block_q0(block_q0), .block_q1(block_q1),
		.word_q(word_q), .xfer_done(xfer_done),
		.ram_index(ram_index), .req_tag(req_tag), .req_offset(req_offset),
		.wdata(wdata), .is_write(is_write), .use_fill(use_fill),
		.tag_d0(tag_d0), .tag_d1(tag_d1),
		.tag_we(tag_we), .data_we0(data_we0), .data_we1(data_we1),
		.start_fill(start_fill), .start_evict(start_evict),
		.block_addr(block_addr), .evict_block(evict_block),
		.rdata_up(rdata_up), .stall_up(stall_up)
	);

	cache_lookup u_cache_lookup (
		.tag_q0(tag_q0), .tag_q1(tag_q1),
		.block_q0(block_q0), .block_q1(block_q1),
		.req_tag(req_tag), .req_offset(req_offset),
		.wdata(wdata), .is_write(is_write),
		.fill_block(fill_block), .use_fill(use_fill),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.word_q(word_q), .line_d(line_d)
	);

	line_transfer u_line_transfer (
		.clk(clk), .reset(reset),
		.start_fill(start_fill), .start_evict(start_evict),
		.block_addr(block_addr), .evict_block(evict_block),
		.ready_mem(ready_mem), .rdata_mem(rdata_mem),
		.read_mem(read_mem), .write_mem(write_mem),
		.addr_mem(addr_mem), .wdata_mem(wdata_mem),
		.fill_block(fill_block), .xfer_done(xfer_done)
	);

	// both tag ways are rewritten together for the used bits
	cache_way_ram #(.entry_t(tag_entry_t)) u_tag0 (
		.clk(clk), .reset(reset), .index(ram_index),
		.d(tag_d0), .we(tag_we), .q(tag_q0)
	);

	cache_way_ram #(.entry_t(tag_entry_t)) u_tag1 (
		.clk(clk), .reset(reset), .index(ram_index),
		.d(tag_d1), .we(tag_we), .q(tag_q1)
	);

	cache_way_ram #(.entry_t(block_t)) u_data0 (
		.clk(clk), .reset(reset), .index(ram_index),
		.d(line_d), .we(data_we0), .q(block_q0)
	);

	cache_way_ram #(.entry_t(block_t)) u_data1 (
		.clk(clk), .reset(reset), .index(ram_index),
		.d(line_d), .we(data_we1), .q(block_q1)
	);

endmodule

/* test/mem_model.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module mem_model import cache_pkg::*; #(
	parameter int AW = 12 // modeled word address bits
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     read_mem,
	input  logic                     write_mem,
	input  logic [`CACHE_ADDR_W-1:0] addr_mem,
	input  word_t                    wdata_mem,
	output logic                     ready_mem,
	output word_t                    rdata_mem
);

	word_t mem [2**AW];
	offset_t beat; // word of the current burst
	logic [AW-1:0] word_addr;

	assign word_addr = {addr_mem[AW-1:`CACHE_OFFSET_W], beat};

	initial begin
		for (int i = 0; i < 2**AW; i++)
			mem[i] = i ^ 32'h5A5A_0F0F; // address with a fixed pattern
		ready_mem = 1'b0;
		rdata_mem = '0;
		void'($urandom(36));
		forever begin
			@(negedge clk);
			ready_mem = ($urandom % 4) != 0;
			rdata_mem = read_mem ? mem[word_addr] : '0;
		end
	end

	always @(posedge clk or negedge reset) begin
		if (!reset)
			beat <= '0;
		else if ((read_mem || write_mem) && ready_mem) begin
			beat <= beat + 1'b1;
			if (write_mem)
				mem[word_addr] <= wdata_mem;
		end else if (!read_mem && !write_mem)
			beat <= '0;
	end

endmodule

/* test/cache_assertions.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_assertions (
	input logic                     clk,
	input logic                     reset,
	input logic                     stall_up,
	input logic                     read_mem,
	input logic                     write_mem,
	input logic [`CACHE_ADDR_W-1:0] addr_mem
);

	stall_after_reset: assert property (@(posedge clk) !reset |=> !stall_up)
		else $error("stall_up high right after reset");

	one_level: assert property (@(posedge clk) disable iff (!reset)
		!(read_mem && write_mem))
		else $error("read_mem and write_mem high together");

	block_aligned: assert property (@(posedge clk) disable iff (!reset)
		(read_mem || write_mem) |-> addr_mem[`CACHE_OFFSET_W-1:0] == '0)
		else $error("addr_mem not block aligned during a burst");

	// address held for the whole burst
	addr_stable: assert property (@(posedge clk) disable iff (!reset)
		(read_mem && $past(read_mem)) || (write_mem && $past(write_mem))
		|-> $stable(addr_mem))
		else $error("addr_mem changed during a burst");

endmodule

bind cache_controller cache_assertions u_cache_assertions (
	.clk(clk), .reset(reset), .stall_up(stall_up),
	.read_mem(read_mem), .write_mem(write_mem), .addr_mem(addr_mem)
);

/* test/cache_tb.sv */
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_tb import cache_pkg::*; ();

	localparam int TIMEOUT = 200; // cycles per wait
	localparam int MEM_AW = 12;

	logic clk = 1'b0;
	logic reset;
	logic read_up;
	logic write_up;
	logic stall_up;
	logic read_mem;
	logic write_mem;
	logic ready_mem;
	logic [`CACHE_ADDR_W-1:0] addr_up;
	logic [`CACHE_ADDR_W-1:0] addr_mem;
	logic [`CACHE_ADDR_W-1:0] read_base;
	logic [`CACHE_ADDR_W-1:0] write_base;
	word_t data_up;
	word_t rdata_up;
	word_t wdata_mem;
	word_t rdata_mem;
	int errors = 0;
	int timeouts = 0;
	int read_beats = 0;
	int write_beats = 0;
	int reads_at_write = 0; // refill beats seen before a write-back beat
	word_t shadow [2**MEM_AW]; // value a read must return
	word_t ref_mem [2**MEM_AW]; // expected main memory

	always #10 clk = ~clk;

	cache_controller u_cache_controller (.*);
	mem_model #(.AW(MEM_AW)) u_mem (.*);

	// memory beats and the block address of each burst
	always @(posedge clk) begin
		if (read_mem && ready_mem) begin
			read_beats++;
			read_base = addr_mem;
		end
		if (write_mem && ready_mem) begin
			write_beats++;
			write_base = addr_mem;
			reads_at_write = read_beats;
		end
	end

	function automatic word_t pattern_word(int unsigned a);
		return a ^ 32'h5A5A_0F0F;
	endfunction

	function automatic logic [`CACHE_ADDR_W-1:0] make_addr(int tag, int index, int offset);
		return (tag << (`CACHE_INDEX_W + `CACHE_OFFSET_W))
			| (index << `CACHE_OFFSET_W) | offset;
	endfunction

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		errors++;
		$display("[ERROR] at %0t ns: %s = %h, expected %h", $time, name, got, exp);
	endtask

	task automatic end_run();
		$display("cache_tb done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	// one request pulse, then wait for stall_up to fall
	task automatic access(input logic wr, input logic [31:0] a, input word_t d,
		output int cycles);
		if (wr)
			shadow[a] = d;
		@(negedge clk);
		read_up = !wr;
		write_up = wr;
		addr_up = a;
		data_up = d;
		@(negedge clk);
		read_up = 1'b0;
		write_up = 1'b0;
		if (!stall_up) begin
			errors++;
			$display("stall_up did not rise for the request to address %h", a);
		end
		cycles = 0;
		while (stall_up && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (stall_up) begin
			timeouts++;
			$display("timed out waiting for stall_up to fall, address %h", a);
			end_run();
		end
	endtask

	task automatic read_check(input logic [31:0] a, output int cycles);
		access(1'b0, a, '0, cycles);
		if (rdata_up !== shadow[a]) report_mismatch("rdata_up", rdata_up, shadow[a]);
	endtask

	task automatic check_traffic(input int rd_exp, input int wr_exp);
		if (read_beats != rd_exp) report_mismatch("read_mem beats", read_beats, rd_exp);
		if (write_beats != wr_exp) report_mismatch("write_mem beats", write_beats, wr_exp);
		read_beats = 0;
		write_beats = 0;
	endtask

	task automatic cold_read_miss();
		int cycles;
		if (stall_up !== 1'b0) report_mismatch("stall_up", stall_up, 0);
		if (read_mem !== 1'b0) report_mismatch("read_mem", read_mem, 0);
		if (write_mem !== 1'b0) report_mismatch("write_mem", write_mem, 0);
		read_check(make_addr(1, 1, 2), cycles);
		check_traffic(4, 0);
		if (read_base !== make_addr(1, 1, 0))
			report_mismatch("addr_mem", read_base, make_addr(1, 1, 0));
	endtask

	task automatic read_hit_one_cycle();
		int cycles;
		read_check(make_addr(1, 1, 3), cycles);
		if (cycles != 1) report_mismatch("stall_up cycles", cycles, 1);
		check_traffic(0, 0);
	endtask

	task automatic write_hit_in_cache();
		int cycles;
		logic [31:0] a;
		a = make_addr(1, 1, 0);
		access(1'b1, a, 32'hDEAD_0001, cycles);
		if (cycles != 1) report_mismatch("stall_up cycles", cycles, 1);
		read_check(a, cycles);
		check_traffic(0, 0);
		if (u_mem.mem[a] !== ref_mem[a])
			report_mismatch("memory word", u_mem.mem[a], ref_mem[a]);
	endtask

	task automatic write_miss_merge();
		int cycles;
		access(1'b1, make_addr(2, 2, 1), 32'hBEEF_0002, cycles);
		check_traffic(4, 0);
		for (int i = 0; i < `CACHE_WORDS; i++) begin
			read_check(make_addr(2, 2, i), cycles); // merged word and refilled ones
			if (cycles != 1) report_mismatch("stall_up cycles", cycles, 1);
		end
		check_traffic(0, 0);
	endtask

	task automatic lru_replacement();
		int cycles;
		read_check(make_addr(1, 3, 0), cycles);
		read_check(make_addr(2, 3, 1), cycles);
		read_check(make_addr(1, 3, 2), cycles); // A again, B now least recent
		if (cycles != 1) report_mismatch("stall_up cycles", cycles, 1);
		check_traffic(8, 0);
		read_check(make_addr(3, 3, 3), cycles);
		check_traffic(4, 0);
		read_check(make_addr(1, 3, 1), cycles);
		if (cycles != 1) report_mismatch("stall_up cycles", cycles, 1);
		read_check(make_addr(2, 3, 0), cycles); // B was replaced
		check_traffic(4, 0);
	endtask

	task automatic dirty_write_back();
		int cycles;
		logic [31:0] a;
		access(1'b1, make_addr(1, 4, 0), 32'h0BAD_0040, cycles);
		access(1'b1, make_addr(1, 4, 3), 32'h0BAD_0043, cycles);
		read_check(make_addr(2, 4, 2), cycles);
		check_traffic(8, 0);
		read_check(make_addr(3, 4, 1), cycles); // victim is the dirty tag 1 block
		check_traffic(4, 4);
		if (reads_at_write != 0)
			report_mismatch("read_mem beats before write-back", reads_at_write, 0);
		if (write_base !== make_addr(1, 4, 0))
			report_mismatch("addr_mem", write_base, make_addr(1, 4, 0));
		if (read_base !== make_addr(3, 4, 0))
			report_mismatch("addr_mem", read_base, make_addr(3, 4, 0));
		for (int i = 0; i < `CACHE_WORDS; i++) begin
			a = make_addr(1, 4, i);
			ref_mem[a] = shadow[a];
			if (u_mem.mem[a] !== ref_mem[a])
				report_mismatch("memory word", u_mem.mem[a], ref_mem[a]);
		end
		read_check(make_addr(1, 4, 0), cycles); // written-back data comes back
		check_traffic(4, 0);
	endtask

	initial begin
		reset = 1'b0;
		read_up = 1'b0;
		write_up = 1'b0;
		addr_up = '0;
		data_up = '0;
		for (int i = 0; i < 2**MEM_AW; i++) begin
			shadow[i] = pattern_word(i);
			ref_mem[i] = pattern_word(i);
		end
		repeat (8) @(negedge clk);
		reset = 1'b1;
		cold_read_miss();
		read_hit_one_cycle();
		write_hit_in_cache();
		write_miss_merge();
		lru_replacement();
		dirty_write_back();
		end_run();
	end

endmodule

/* cache_ctrl.f */
+incdir+design
design/cache_pkg.sv
design/cache_way_ram.sv
design/cache_lookup.sv
design/line_transfer.sv
design/cache_fsm.sv
design/cache_controller.sv
test/mem_model.sv
test/cache_assertions.sv
test/cache_tb.sv
